/* list.f */
+incdir+source
source/uart_pkg.sv
source/baud_gen.sv
source/uart_rx.sv
source/uart_tx.sv
source/alu_frontend.sv
source/uart_alu_top.sv
tests/uart_alu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= uart_alu_tb
FILELIST  ?= list.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir

/* tests/uart_alu_tb.sv */
`timescale 1ns/100ps
`include "uart_consts.svh"

module uart_alu_tb;

	localparam int TICK_DIV   = `UART_TICK_DIV;
	localparam int BIT_CLKS   = `UART_OVERSAMPLE * TICK_DIV; // clocks per serial bit
	localparam int HALF_BIT   = BIT_CLKS / 2;
	localparam int FRAME_CLKS = 10 * BIT_CLKS;
	localparam int NUM_ROWS   = 20;
	localparam int NUM_RAND   = 3; // last rows get random operands
	localparam int LIMIT      = NUM_ROWS * 4 * 160 * TICK_DIV + 16 * FRAME_CLKS;

	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] op;  // whole opcode byte as sent
		logic       bad; // junk frame with low stop bit goes first
		logic       ovl; // next command starts while this reply is on tx
		logic [7:0] exp;
	} row_t;

	logic            clk = 1'b0;
	logic            rst_n;
	logic            rx;
	logic            tx;
	uart_pkg::data_t leds;

	row_t       rows [NUM_ROWS];
	logic [7:0] got_bytes [64]; // reply bytes in arrival order
	int         got_cnt;
	int         starts; // start edges seen on tx
	int         frame_errs;
	int         errors;
	int         rd_idx;
	int         cycles = 0;

	uart_alu_top u_dut (
		.clk   (clk),
		.rst_n (rst_n),
		.rx    (rx),
		.tx    (tx),
		.leds  (leds)
	);

	always #20 clk = ~clk; // 40 ns period

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: run still going after %0d clock cycles", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	// reference alu straight from the opcode table
	function automatic logic [7:0] alu_model(input logic [7:0] a, input logic [7:0] b,
			input logic [7:0] op);
		logic [15:0] wide;
		wide = {{8{a[7]}}, a} >> b[2:0]; // sign copies slide into the low byte
		case (op[5:0]) // top two opcode bits don't matter
			6'b100000: alu_model = a + b;
			6'b100010: alu_model = a - b;
			6'b100100: alu_model = a & b;
			6'b100101: alu_model = a | b;
			6'b100110: alu_model = a ^ b;
			6'b100111: alu_model = ~(a | b);
			6'b000011: alu_model = wide[7:0]; // arithmetic
			6'b000010: alu_model = a >> b[2:0]; // logical
			default:   alu_model = 8'h00;
		endcase
	endfunction

	task automatic load_table();
		int r;
		rows[0]  = '{8'h3c, 8'h17, 8'h20, 1'b0, 1'b0, 8'h53}; // add
		rows[1]  = '{8'hf0, 8'h25, 8'h20, 1'b0, 1'b0, 8'h15}; // add wraps
		rows[2]  = '{8'h50, 8'h12, 8'h22, 1'b0, 1'b0, 8'h3e}; // sub
		rows[3]  = '{8'h10, 8'h20, 8'h22, 1'b0, 1'b0, 8'hf0}; // sub wraps
		rows[4]  = '{8'hcc, 8'haa, 8'h24, 1'b0, 1'b0, 8'h88}; // and
		rows[5]  = '{8'hc0, 8'h0a, 8'h25, 1'b0, 1'b0, 8'hca}; // or
		rows[6]  = '{8'hff, 8'h5a, 8'h26, 1'b0, 1'b0, 8'ha5}; // xor
		rows[7]  = '{8'h0f, 8'h30, 8'h27, 1'b0, 1'b0, 8'hc0}; // nor
		rows[8]  = '{8'h90, 8'h03, 8'h03, 1'b0, 1'b0, 8'hf2}; // sra, sign fill
		rows[9]  = '{8'h40, 8'hfa, 8'h03, 1'b0, 1'b0, 8'h10}; // sra, only b[2:0] counts
		rows[10] = '{8'h90, 8'h0b, 8'h02, 1'b0, 1'b0, 8'h12}; // srl
		rows[11] = '{8'h12, 8'h34, 8'h3f, 1'b0, 1'b0, 8'h00}; // unknown opcode
		rows[12] = '{8'h01, 8'h02, 8'he0, 1'b0, 1'b0, 8'h03}; // add with junk top bits
		rows[13] = '{8'h21, 8'h43, 8'h20, 1'b1, 1'b0, 8'h64}; // after a dropped frame
		rows[14] = '{8'h11, 8'h22, 8'h26, 1'b0, 1'b1, 8'h33}; // back to back
		rows[15] = '{8'h7e, 8'h3c, 8'h24, 1'b0, 1'b1, 8'h3c};
		rows[16] = '{8'h80, 8'h01, 8'h25, 1'b0, 1'b0, 8'h81};
		rows[17].op = 8'h20;
		rows[18].op = 8'h22;
		rows[19].op = 8'h26;
		for (r = NUM_ROWS - NUM_RAND; r < NUM_ROWS; r++) begin
			rows[r].a   = 8'($urandom());
			rows[r].b   = 8'($urandom());
			rows[r].bad = 1'b0;
			rows[r].ovl = 1'b0;
			rows[r].exp = alu_model(rows[r].a, rows[r].b, rows[r].op);
		end
	endtask

	// one 8N1 frame, called on a falling edge
	task automatic send_byte(input logic [7:0] val, input logic bad_stop);
		int i;
		rx = 1'b0; // start bit
		repeat (BIT_CLKS) @(negedge clk);
		for (i = 0; i < 8; i++) begin
			rx = val[i]; // lsb first
			repeat (BIT_CLKS) @(negedge clk);
		end
		rx = !bad_stop;
		repeat (BIT_CLKS) @(negedge clk);
		if (bad_stop) begin
			rx = 1'b1; // back to idle so the next start edge shows
			repeat (BIT_CLKS) @(negedge clk);
		end
	endtask

	// reply monitor, mid-bit sampling
	initial begin : capture
		logic [7:0] byte_v;
		int         i;
		got_cnt    = 0;
		starts     = 0;
		frame_errs = 0;
		@(posedge rst_n);
		forever begin
			@(negedge clk);
			if (tx === 1'b0) begin
				starts++;
				repeat (HALF_BIT) @(negedge clk);
				assert (tx === 1'b0) else begin
					$display("[ERROR] tx start bit = %h, expected 0", tx);
					frame_errs++;
				end
				for (i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge clk);
					byte_v[i] = tx;
				end
				repeat (BIT_CLKS) @(negedge clk);
				assert (tx === 1'b1) else begin
					$display("[ERROR] tx stop bit = %h, expected 1", tx);
					frame_errs++;
				end
				got_bytes[got_cnt] = byte_v;
				got_cnt++;
			end
		end
	end

	initial begin : stimulus
		int   r;
		int   n;
		int   last;
		int   pend_rows [$]; // rows whose replies are still due
		logic idle_ok;
		logic ok;

		void'($urandom(32'h6dc64665));
		errors = 0;
		rd_idx = 0;
		rx     = 1'b1; // line idles high
		rst_n  = 1'b0;
		load_table();
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		// quiet line and dark leds for one frame time
		idle_ok = 1'b1;
		for (n = 0; n < FRAME_CLKS && idle_ok; n++) begin
			@(negedge clk);
			assert (tx === 1'b1) else begin
				$display("[ERROR] tx = %h, expected 1", tx);
				idle_ok = 1'b0;
			end
			assert (leds === 8'h00) else begin
				$display("[ERROR] leds = %h, expected 00", leds);
				idle_ok = 1'b0;
			end
		end
		if (!idle_ok) errors++;
		$display("test idle: %s", idle_ok ? "ok" : "wrong");

		for (r = 0; r < NUM_ROWS; r++) begin
			if (rows[r].bad) send_byte(8'h55, 1'b1); // rx should drop this one
			send_byte(rows[r].a, 1'b0);
			send_byte(rows[r].b, 1'b0);
			if (rows[r].bad) begin
				assert (starts == rd_idx + pend_rows.size()) else begin
					$display("reply started before the opcode of test %0d was sent", r);
					errors++;
				end
			end
			send_byte(rows[r].op, 1'b0);
			pend_rows.push_back(r);
			if (!rows[r].ovl) begin
				while (pend_rows.size() > 0) begin
					last = pend_rows.pop_front();
					while (got_cnt <= rd_idx) @(negedge clk);
					ok = (got_bytes[rd_idx] === rows[last].exp);
					assert (ok) else begin
						$display("[ERROR] tx byte = %h, expected %h",
							got_bytes[rd_idx], rows[last].exp);
						errors++;
					end
					$display("test %0d: a=%h b=%h op=%h reply=%h %s", last, rows[last].a,
						rows[last].b, rows[last].op, got_bytes[rd_idx], ok ? "ok" : "wrong");
					rd_idx++;
				end
				assert (leds === rows[last].exp) else begin
					$display("[ERROR] leds = %h, expected %h", leds, rows[last].exp);
					errors++;
				end
			end
		end

		repeat (FRAME_CLKS) @(negedge clk); // nothing else may come out
		assert (got_cnt == rd_idx && starts == rd_idx) else begin
			$display("%0d replies seen on tx but %0d expected", starts, rd_idx);
			errors++;
		end

		$display("%0d tests, %0d errors", NUM_ROWS + 1, errors + frame_errs);
		if (errors + frame_errs == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* source/uart_alu_top.sv */
`timescale 1ns/100ps

// serial alu
// rx frames -> frontend -> tx frame, result mirrored on leds
module uart_alu_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            rx,
	output logic            tx,
	output uart_pkg::data_t leds
);

	logic            tick; // shared 16x oversample tick
	logic            rx_done;
	logic            tx_start;
	logic            tx_done;
	uart_pkg::data_t rx_data;
	uart_pkg::data_t tx_data;

	baud_gen u_baud (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	uart_rx u_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.rx      (rx), // serial line in
		.tick    (tick),
		.rx_done (rx_done),
		.rx_data (rx_data)
	);

	alu_frontend u_fe (
		.clk      (clk),
		.rst_n    (rst_n),
		.rx_done  (rx_done),
		.rx_data  (rx_data),
		.tx_done  (tx_done),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.result   (leds) // last computed result
	);

	uart_tx u_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick     (tick),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_done  (tx_done),
		.tx       (tx) // serial line out
	);

endmodule

/* source/alu_frontend.sv */
`timescale 1ns/100ps

// three-byte command in, one result byte out
// operand a, operand b, then opcode
module alu_frontend (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            rx_done,
	input  uart_pkg::data_t rx_data,
	input  logic            tx_done,
	output logic            tx_start,
	output uart_pkg::data_t tx_data,
	output uart_pkg::data_t result
);

	uart_pkg::fe_state_t state;
	uart_pkg::data_t     op_a;
	uart_pkg::data_t     op_b;
	uart_pkg::data_t     alu_res;
	uart_pkg::alu_op_t   opcode;

	logic [2:0] shamt; // shift amount from b
	logic       busy; // set at tx_start, cleared at tx_done
	logic       pend; // result waiting for the transmitter
	logic       launch;

	assign opcode = uart_pkg::alu_op_t'(rx_data[5:0]); // top two bits ignored
	assign shamt  = op_b[2:0];
	assign launch = pend && !busy;

	// only used in the opcode cycle
	always_comb begin
		case (opcode)
			uart_pkg::ADD: alu_res = op_a + op_b; // wraps at 8 bits
			uart_pkg::SUB: alu_res = op_a - op_b;
			uart_pkg::AND: alu_res = op_a & op_b;
			uart_pkg::OR:  alu_res = op_a | op_b;
			uart_pkg::XOR: alu_res = op_a ^ op_b;
			uart_pkg::NOR: alu_res = ~(op_a | op_b);
			uart_pkg::SRA: alu_res = $unsigned($signed(op_a) >>> shamt); // sign fill
			uart_pkg::SRL: alu_res = op_a >> shamt;
			default:       alu_res = '0; // unknown opcode
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= uart_pkg::GET_A;
			result   <= '0; // leds dark after reset
			busy     <= 1'b0;
			pend     <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (tx_done) busy <= 1'b0; // launch waits one more clock

			if (launch) begin
				tx_start <= 1'b1;
				busy     <= 1'b1;
				pend     <= 1'b0;
			end

			// keeps assembling while a reply goes out
			if (rx_done) begin
				case (state)
					uart_pkg::GET_A:  state <= uart_pkg::GET_B;
					uart_pkg::GET_B:  state <= uart_pkg::GET_OP;
					uart_pkg::GET_OP: begin
						result <= alu_res;
						pend   <= 1'b1; // newest result overwrites the pending one
						state  <= uart_pkg::GET_A;
					end
					default: state <= uart_pkg::GET_A;
				endcase
			end
		end
	end

	// operands and outgoing byte
	always_ff @(posedge clk) begin
		if (rx_done && state == uart_pkg::GET_A) op_a <= rx_data;
		if (rx_done && state == uart_pkg::GET_B) op_b <= rx_data;
		if (launch) tx_data <= result; // stable until tx_done
	end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/100ps
`include "uart_consts.svh"

// 8N1 transmitter
// start pulse in, done pulse out 160 ticks later
module uart_tx (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            tick,
	input  logic            tx_start,
	input  uart_pkg::data_t tx_data,
	output logic            tx_done,
	output logic            tx
);

	localparam uart_pkg::tick_cnt_t LAST_TICK =
		uart_pkg::tick_cnt_t'(`UART_OVERSAMPLE - 1);
	localparam uart_pkg::bit_cnt_t LAST_BIT =
		uart_pkg::bit_cnt_t'(`UART_DATA_W - 1);

	uart_pkg::tx_state_t state;
	uart_pkg::tick_cnt_t tick_cnt;
	uart_pkg::bit_cnt_t  bit_cnt;
	uart_pkg::data_t     shreg; // current bit sits in [0]

	logic load;
	logic bit_end;

	assign load    = (state == uart_pkg::IDLE) && tx_start;
	assign bit_end = tick && (tick_cnt == LAST_TICK); // 16 ticks per bit

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= uart_pkg::IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx_done  <= 1'b0;
			tx       <= 1'b1; // mark level
		end else begin
			tx_done <= 1'b0;
			if (state != uart_pkg::IDLE && tick) tick_cnt <= tick_cnt + 1'b1;

			case (state)
				uart_pkg::IDLE: begin
					tx <= 1'b1;
					if (tx_start) begin
						tick_cnt <= '0;
						bit_cnt  <= '0;
						tx       <= 1'b0; // start bit
						state    <= uart_pkg::START;
					end
				end
				uart_pkg::START: begin
					if (bit_end) begin
						tx    <= shreg[0]; // first data bit
						state <= uart_pkg::DATA;
					end
				end
				uart_pkg::DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT) begin
							tx    <= 1'b1; // stop bit
							state <= uart_pkg::STOP;
						end else begin
							tx <= shreg[1]; // shreg shifts this same edge
						end
					end
				end
				uart_pkg::STOP: begin
					if (bit_end) begin
						tx_done <= 1'b1;
						state   <= uart_pkg::IDLE;
					end
				end
				default: state <= uart_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load) shreg <= tx_data;
		else if (state == uart_pkg::DATA && bit_end) shreg <= shreg >> 1;
	end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/100ps
`include "uart_consts.svh"

// 8N1 receiver, 16x oversampled
module uart_rx (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            rx,
	input  logic            tick,
	output logic            rx_done,
	output uart_pkg::data_t rx_data
);

	// middle of the start bit
	localparam uart_pkg::tick_cnt_t MID_TICK =
		uart_pkg::tick_cnt_t'(`UART_OVERSAMPLE / 2 - 1);
	localparam uart_pkg::tick_cnt_t LAST_TICK =
		uart_pkg::tick_cnt_t'(`UART_OVERSAMPLE - 1);
	localparam uart_pkg::bit_cnt_t LAST_BIT =
		uart_pkg::bit_cnt_t'(`UART_DATA_W - 1);

	uart_pkg::rx_state_t state;
	uart_pkg::tick_cnt_t tick_cnt;
	uart_pkg::bit_cnt_t  bit_cnt;
	uart_pkg::data_t     shreg; // bits land here msb side, shift toward lsb

	logic rx_meta; // first sync stage
	logic rx_sync;
	logic rx_prev; // for edge detect
	logic fall;
	logic bit_end; // 16th tick of a data or stop bit
	logic sample;
	logic frame_ok;

	assign fall     = rx_prev & ~rx_sync;
	assign bit_end  = tick && (tick_cnt == LAST_TICK);
	assign sample   = (state == uart_pkg::DATA) && bit_end; // mid data bit
	assign frame_ok = (state == uart_pkg::STOP) && bit_end && rx_sync; // stop must be high

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_meta  <= 1'b1; // idle line level
			rx_sync  <= 1'b1;
			rx_prev  <= 1'b1;
			state    <= uart_pkg::IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			rx_done <= frame_ok; // bad stop bit just drops the frame

			case (state)
				uart_pkg::IDLE: begin
					if (fall) begin
						tick_cnt <= '0;
						state    <= uart_pkg::START;
					end
				end
				uart_pkg::START: begin
					if (tick) begin
						if (tick_cnt == MID_TICK) begin
							tick_cnt <= '0; // realign to mid-bit
							bit_cnt  <= '0;
							// glitch if the line went back high
							state    <= rx_sync ? uart_pkg::IDLE : uart_pkg::DATA;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				uart_pkg::DATA: begin
					if (tick) tick_cnt <= tick_cnt + 1'b1; // wraps every bit
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == LAST_BIT) state <= uart_pkg::STOP;
					end
				end
				uart_pkg::STOP: begin
					if (tick) tick_cnt <= tick_cnt + 1'b1;
					if (bit_end) state <= uart_pkg::IDLE; // mid stop bit
				end
				default: state <= uart_pkg::IDLE;
			endcase
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (sample) shreg <= {rx_sync, shreg[`UART_DATA_W-1:1]}; // lsb first
		if (frame_ok) rx_data <= shreg; // held until next good frame
	end

endmodule

/* source/baud_gen.sv */
`timescale 1ns/100ps
`include "uart_consts.svh"

// one tick per UART_TICK_DIV clocks
// rx and tx both run off this phase
module baud_gen (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	localparam int DIV = `UART_TICK_DIV;
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1; // keep at least one bit

	logic [CNT_W-1:0] div_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else if (div_cnt == CNT_W'(DIV - 1)) begin
			div_cnt <= '0; // wrap
			tick    <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick    <= 1'b0;
		end
	end

endmodule

/* source/uart_pkg.sv */
`include "uart_consts.svh"

package uart_pkg;
	typedef logic [`UART_DATA_W-1:0] data_t; // one frame payload
	typedef logic [3:0] tick_cnt_t; // oversample tick count within a bit
	typedef logic [2:0] bit_cnt_t; // data bit index, lsb first

	// low six bits of the opcode byte
	typedef enum logic [5:0] {
		ADD = 6'b100000,
		SUB = 6'b100010,
		AND = 6'b100100,
		OR  = 6'b100101,
		XOR = 6'b100110,
		NOR = 6'b100111,
		SRA = 6'b000011,
		SRL = 6'b000010
	} alu_op_t;

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} line_state_t;
	typedef line_state_t rx_state_t; // rx and tx walk the same frame
	typedef line_state_t tx_state_t;
	typedef enum logic [1:0] {GET_A, GET_B, GET_OP} fe_state_t;
endpackage

/* source/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// system clock in hz
`define UART_CLK_HZ 25000000

// line rate picked high so sims stay short
`define UART_BAUD 781250

// oversample ticks per serial bit
`define UART_OVERSAMPLE 16

// clocks per oversample tick
// works out to 2 with the numbers above
`define UART_TICK_DIV (`UART_CLK_HZ / (`UART_BAUD * `UART_OVERSAMPLE))

// payload bits per 8N1 frame
`define UART_DATA_W 8

`endif
